// ==== hw/cache_pkg.sv ====
package cache_pkg;

    localparam int way_count      = 4;
    localparam int set_count      = 16;
    localparam int tag_bits       = 23;
    localparam int set_bits       = 4;
    localparam int offset_bits    = 5;
    localparam int line_bits      = 256;
    localparam int words_per_line = 8;

    typedef logic [31:0]                         addr_t;
    typedef logic [tag_bits-1:0]                 tag_t;
    typedef logic [set_bits-1:0]                 set_t;
    typedef logic [$clog2(words_per_line)-1:0]   word_sel_t;
    typedef logic [31:0]                         word_t;
    typedef logic [3:0]                          byte_mask_t;
    typedef logic [line_bits-1:0]                line_t;
    typedef logic [$clog2(way_count)-1:0]        way_t;
    typedef logic [way_count-1:0]                way_vec_t;
    // {root, left pair, right pair}
    typedef logic [2:0]                          plru_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_compare,
        st_miss_wait,
        st_refill,
        st_respond
    } cache_state_t;

endpackage

// ==== hw/cache_req_latch.sv ====
`timescale 1ns/1ps

module cache_req_latch (
    input  logic                   clk,
    input  logic                   rst,
    input  cache_pkg::addr_t       ufp_addr,
    input  cache_pkg::byte_mask_t  ufp_rmask,
    input  cache_pkg::byte_mask_t  ufp_wmask,
    input  cache_pkg::word_t       ufp_wdata,
    input  logic                   capture,
    output cache_pkg::tag_t        req_tag,
    output cache_pkg::set_t        req_set,
    output cache_pkg::word_sel_t   req_word,
    output cache_pkg::byte_mask_t  req_rmask,
    output cache_pkg::byte_mask_t  req_wmask,
    output cache_pkg::word_t       req_wdata,
    output logic                   req_seen
);
    import cache_pkg::*;

    logic present;
    logic load;

    assign present = (|ufp_rmask) || (|ufp_wmask);
    // a request taken on the previous edge is not taken twice
    assign load = capture && present && !req_seen;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_seen  <= 1'b0;
            req_rmask <= '0;
            req_wmask <= '0;
        end else begin
            req_seen <= load;
            if (load) begin
                req_rmask <= ufp_rmask;
                req_wmask <= ufp_wmask;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            req_tag   <= ufp_addr[31:set_bits+offset_bits];
            req_set   <= ufp_addr[set_bits+offset_bits-1:offset_bits];
            req_word  <= ufp_addr[offset_bits-1:2];
            req_wdata <= ufp_wdata;
        end
    end

    a_one_mask: assert property (@(posedge clk) disable iff (rst)
        !((|ufp_rmask) && (|ufp_wmask)));

endmodule

// ==== hw/cache_way_store.sv ====
`timescale 1ns/1ps

module cache_way_store (
    input  logic                 clk,
    input  logic                 rst,
    input  cache_pkg::set_t      rd_set,
    input  cache_pkg::tag_t      cmp_tag,
    input  cache_pkg::way_vec_t  wr_tag,
    input  cache_pkg::way_vec_t  wr_data,
    input  cache_pkg::way_vec_t  wr_dirty,
    input  cache_pkg::line_t     wr_line,
    input  cache_pkg::tag_t      wr_tag_val,
    input  logic                 wr_dirty_val,
    output cache_pkg::line_t     rd_lines [cache_pkg::way_count],
    output cache_pkg::tag_t      rd_tags [cache_pkg::way_count],
    output cache_pkg::way_vec_t  rd_dirty,
    output logic                 hit,
    output cache_pkg::way_t      hit_way
);
    import cache_pkg::*;

    line_t    data_arr [set_count][way_count];
    tag_t     tag_arr [set_count][way_count];
    way_vec_t valid_arr [set_count];
    way_vec_t dirty_arr [set_count];
    way_vec_t rd_valid;
    way_vec_t match;

    // payload arrays
    always_ff @(posedge clk) begin
        for (int w = 0; w < way_count; w++) begin
            if (wr_data[w]) data_arr[rd_set][w] <= wr_line;
            if (wr_tag[w]) tag_arr[rd_set][w] <= wr_tag_val;
            rd_lines[w] <= data_arr[rd_set][w];
            rd_tags[w]  <= tag_arr[rd_set][w];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < set_count; s++) begin
                valid_arr[s] <= '0;
                dirty_arr[s] <= '0;
            end
            rd_valid <= '0;
            rd_dirty <= '0;
        end else begin
            for (int w = 0; w < way_count; w++) begin
                // tag write also marks the way valid
                if (wr_tag[w]) valid_arr[rd_set][w] <= 1'b1;
                if (wr_dirty[w]) dirty_arr[rd_set][w] <= wr_dirty_val;
            end
            rd_valid <= valid_arr[rd_set];
            rd_dirty <= dirty_arr[rd_set];
        end
    end

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = way_count - 1; w >= 0; w--) begin
            match[w] = rd_valid[w] && (rd_tags[w] == cmp_tag);
            if (match[w]) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    a_single_match: assert property (@(posedge clk) disable iff (rst)
        $onehot0(match));

endmodule

// ==== hw/cache_plru.sv ====
`timescale 1ns/1ps

module cache_plru (
    input  logic             clk,
    input  logic             rst,
    input  cache_pkg::set_t  set,
    input  logic             touch,
    input  cache_pkg::way_t  touch_way,
    output cache_pkg::way_t  victim_way
);
    import cache_pkg::*;

    plru_t tree [set_count];
    plru_t cur;
    plru_t nxt;

    assign cur = tree[set];

    // root 0 means the left pair was used last
    always_comb begin
        if (!cur[2]) begin
            victim_way = cur[0] ? way_t'(2) : way_t'(3);
        end else begin
            victim_way = cur[1] ? way_t'(0) : way_t'(1);
        end
    end

    always_comb begin
        case (touch_way)
            2'd0:    nxt = {1'b0, 1'b0, cur[0]};
            2'd1:    nxt = {1'b0, 1'b1, cur[0]};
            2'd2:    nxt = {1'b1, cur[1], 1'b0};
            default: nxt = {1'b1, cur[1], 1'b1};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < set_count; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            tree[set] <= nxt;
        end
    end

endmodule

// ==== hw/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  cache_pkg::tag_t        req_tag,
    input  cache_pkg::set_t        req_set,
    input  cache_pkg::word_sel_t   req_word,
    input  cache_pkg::byte_mask_t  req_rmask,
    input  cache_pkg::byte_mask_t  req_wmask,
    input  cache_pkg::word_t       req_wdata,
    input  logic                   req_seen,
    input  cache_pkg::line_t       rd_lines [cache_pkg::way_count],
    input  cache_pkg::tag_t        rd_tags [cache_pkg::way_count],
    input  cache_pkg::way_vec_t    rd_dirty,
    input  logic                   hit,
    input  cache_pkg::way_t        hit_way,
    input  cache_pkg::way_t        victim_way,
    input  logic                   fill_done,
    input  cache_pkg::line_t       fill_line,
    output logic                   capture,
    output cache_pkg::way_vec_t    wr_tag,
    output cache_pkg::way_vec_t    wr_data,
    output cache_pkg::way_vec_t    wr_dirty,
    output cache_pkg::line_t       wr_line,
    output logic                   wr_dirty_val,
    output logic                   touch,
    output cache_pkg::way_t        touch_way,
    output logic                   miss_start,
    output logic                   victim_dirty,
    output cache_pkg::line_t       victim_line,
    output cache_pkg::tag_t        victim_tag,
    output cache_pkg::word_t       ufp_rdata,
    output cache_pkg::line_t       ufp_rline,
    output logic                   ufp_resp
);
    import cache_pkg::*;

    cache_state_t state;
    cache_state_t next_state;
    logic         is_write;
    logic         is_read;
    line_t        base_line;

    function automatic line_t merge_bytes(line_t base, word_sel_t sel, byte_mask_t mask,
                                          word_t data);
        line_t res;
        res = base;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) res[sel * 32 + b * 8 +: 8] = data[b * 8 +: 8];
        end
        return res;
    endfunction

    assign is_write = |req_wmask;
    assign is_read  = |req_rmask;

    always_comb begin
        next_state = state;
        case (state)
            st_idle:      if (req_seen) next_state = st_lookup;
            st_lookup:    next_state = st_compare;
            st_compare:   next_state = hit ? st_idle : st_miss_wait;
            st_miss_wait: if (fill_done) next_state = st_refill;
            st_refill:    next_state = st_respond;
            default:      next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            capture <= 1'b0;
        end else begin
            state   <= next_state;
            capture <= (next_state == st_idle);
        end
    end

    assign victim_dirty = rd_dirty[victim_way];
    assign victim_line  = rd_lines[victim_way];
    assign victim_tag   = rd_tags[victim_way];
    assign miss_start   = (state == st_compare) && !hit;

    // refill stores the fetched line, a write hit rewrites the hit line
    assign base_line    = (state == st_refill) ? fill_line : rd_lines[hit_way];
    assign wr_line      = merge_bytes(base_line, req_word, req_wmask, req_wdata);
    assign wr_dirty_val = is_write;

    always_comb begin
        wr_tag    = '0;
        wr_data   = '0;
        wr_dirty  = '0;
        touch     = 1'b0;
        touch_way = hit_way;
        if (state == st_compare && hit) begin
            touch = 1'b1;
            if (is_write) begin
                wr_data[hit_way]  = 1'b1;
                wr_dirty[hit_way] = 1'b1;
            end
        end else if (state == st_refill) begin
            touch               = 1'b1;
            touch_way           = victim_way;
            wr_tag[victim_way]  = 1'b1;
            wr_data[victim_way] = 1'b1;
            wr_dirty[victim_way] = 1'b1;
        end
    end

    assign ufp_resp  = (state == st_compare && hit) || (state == st_respond);
    assign ufp_rline = !is_read ? '0 : (state == st_respond) ? fill_line : rd_lines[hit_way];
    assign ufp_rdata = ufp_rline[req_word * 32 +: 32];

    // a response always belongs to exactly one latched read or write
    a_resp_state: assert property (@(posedge clk) disable iff (rst)
        ufp_resp |-> (is_read ^ is_write));

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (state == st_lookup) |=> $stable(req_tag) && $stable(req_set));

endmodule

// ==== hw/cache_mem_port.sv ====
`timescale 1ns/1ps

module cache_mem_port (
    input  logic              clk,
    input  logic              rst,
    input  logic              miss_start,
    input  logic              victim_dirty,
    input  cache_pkg::line_t  victim_line,
    input  cache_pkg::tag_t   victim_tag,
    input  cache_pkg::tag_t   req_tag,
    input  cache_pkg::set_t   req_set,
    input  cache_pkg::line_t  dfp_rdata,
    input  logic              dfp_resp,
    output cache_pkg::addr_t  dfp_addr,
    output logic              dfp_read,
    output logic              dfp_write,
    output cache_pkg::line_t  dfp_wdata,
    output logic              fill_done,
    output cache_pkg::line_t  fill_line
);
    import cache_pkg::*;

    tag_t wb_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            dfp_read  <= 1'b0;
            dfp_write <= 1'b0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= dfp_read && dfp_resp;
            if (miss_start) begin
                dfp_write <= victim_dirty;
                dfp_read  <= !victim_dirty;
            end else if (dfp_write && dfp_resp) begin
                dfp_write <= 1'b0;
                dfp_read  <= 1'b1;
            end else if (dfp_read && dfp_resp) begin
                dfp_read <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss_start) begin
            wb_tag    <= victim_tag;
            dfp_wdata <= victim_line;
        end
        if (dfp_read && dfp_resp) fill_line <= dfp_rdata;
    end

    // writeback goes to the victim's line, refill to the requested one
    assign dfp_addr = dfp_write ? {wb_tag, req_set, {offset_bits{1'b0}}}
                                : {req_tag, req_set, {offset_bits{1'b0}}};

    // a memory request keeps its level and address until the response
    a_level_held: assert property (@(posedge clk) disable iff (rst)
        (dfp_read || dfp_write) && !dfp_resp |=> $stable(dfp_addr) && $stable(dfp_read)
            && $stable(dfp_write));

endmodule

// ==== hw/cache_top.sv ====
`timescale 1ns/1ps

module cache_top (
    input  logic                   clk,
    input  logic                   rst,
    input  cache_pkg::addr_t       ufp_addr,
    input  cache_pkg::byte_mask_t  ufp_rmask,
    input  cache_pkg::byte_mask_t  ufp_wmask,
    input  cache_pkg::word_t       ufp_wdata,
    output cache_pkg::word_t       ufp_rdata,
    output cache_pkg::line_t       ufp_rline,
    output logic                   ufp_resp,
    output cache_pkg::addr_t       dfp_addr,
    output logic                   dfp_read,
    output logic                   dfp_write,
    output cache_pkg::line_t       dfp_wdata,
    input  cache_pkg::line_t       dfp_rdata,
    input  logic                   dfp_resp
);
    import cache_pkg::*;

    tag_t       req_tag;
    set_t       req_set;
    word_sel_t  req_word;
    byte_mask_t req_rmask;
    byte_mask_t req_wmask;
    word_t      req_wdata;
    logic       req_seen;
    logic       capture;
    way_vec_t   wr_tag;
    way_vec_t   wr_data;
    way_vec_t   wr_dirty;
    line_t      wr_line;
    logic       wr_dirty_val;
    line_t      rd_lines [way_count];
    tag_t       rd_tags [way_count];
    way_vec_t   rd_dirty;
    logic       hit;
    way_t       hit_way;
    logic       touch;
    way_t       touch_way;
    way_t       victim_way;
    logic       miss_start;
    logic       victim_dirty;
    line_t      victim_line;
    tag_t       victim_tag;
    logic       fill_done;
    line_t      fill_line;

    cache_req_latch u_latch (
        .clk, .rst, .ufp_addr, .ufp_rmask, .ufp_wmask, .ufp_wdata, .capture,
        .req_tag, .req_set, .req_word, .req_rmask, .req_wmask, .req_wdata, .req_seen
    );

    cache_way_store u_store (
        .clk, .rst, .rd_set(req_set), .cmp_tag(req_tag),
        .wr_tag, .wr_data, .wr_dirty, .wr_line, .wr_tag_val(req_tag), .wr_dirty_val,
        .rd_lines, .rd_tags, .rd_dirty, .hit, .hit_way
    );

    cache_plru u_plru (
        .clk, .rst, .set(req_set), .touch, .touch_way, .victim_way
    );

    cache_ctrl u_ctrl (
        .clk, .rst, .req_tag, .req_set, .req_word, .req_rmask, .req_wmask, .req_wdata,
        .req_seen, .rd_lines, .rd_tags, .rd_dirty, .hit, .hit_way, .victim_way,
        .fill_done, .fill_line, .capture, .wr_tag, .wr_data, .wr_dirty, .wr_line,
        .wr_dirty_val, .touch, .touch_way, .miss_start, .victim_dirty, .victim_line,
        .victim_tag, .ufp_rdata, .ufp_rline, .ufp_resp
    );

    cache_mem_port u_mem (
        .clk, .rst, .miss_start, .victim_dirty, .victim_line, .victim_tag,
        .req_tag, .req_set, .dfp_rdata, .dfp_resp, .dfp_addr, .dfp_read, .dfp_write,
        .dfp_wdata, .fill_done, .fill_line
    );

endmodule

// ==== testbench/tb_cache.sv ====
`timescale 1ns/1ps

module tb_cache;
    import cache_pkg::*;

    localparam int n_random = 400;
    localparam int n_lines  = 128;
    localparam int n_access = 11 + n_random + n_lines;
    localparam int max_cycles = n_access * 40 + 1000;

    typedef struct packed {
        logic        is_read;
        logic        hit;
        word_t       word;
        line_t       line;
        int unsigned start;
    } resp_exp_t;

    typedef struct packed {
        logic  is_write;
        addr_t addr;
        line_t data;
    } mem_op_t;

    logic clk;
    logic rst;
    addr_t ufp_addr;
    byte_mask_t ufp_rmask;
    byte_mask_t ufp_wmask;
    word_t ufp_wdata;
    word_t ufp_rdata;
    line_t ufp_rline;
    logic ufp_resp;
    addr_t dfp_addr;
    logic dfp_read;
    logic dfp_write;
    line_t dfp_wdata;
    line_t dfp_rdata;
    logic dfp_resp;

    line_t mem_lines [n_lines];
    logic [7:0] shadow_bytes [4096];
    tag_t sh_tag [set_count][way_count];
    logic sh_valid [set_count][way_count];
    logic sh_dirty [set_count][way_count];
    plru_t sh_tree [set_count];

    resp_exp_t resp_q[$];
    mem_op_t exp_ops[$];
    resp_exp_t exp_resp;
    int err_count = 0;
    int wb_count = 0;
    int unsigned cyc = 0;

    cache_top dut (
        .clk, .rst, .ufp_addr, .ufp_rmask, .ufp_wmask, .ufp_wdata, .ufp_rdata, .ufp_rline,
        .ufp_resp, .dfp_addr, .dfp_read, .dfp_write, .dfp_wdata, .dfp_rdata, .dfp_resp
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic compare_value(string name, line_t got, line_t exp);
        assert (got === exp) else begin
            err_count++;
            $display("ERR %s got %0h exp %0h", name, got, exp);
        end
    endtask

    // expected word and whole line from the shadow bytes
    function automatic word_t ref_read_word(addr_t a, output line_t line);
        logic [11:0] base;
        base = {a[11:5], 5'b0};
        for (int b = 0; b < 32; b++) begin
            line[b * 8 +: 8] = shadow_bytes[base + 12'(b)];
        end
        return line[a[4:2] * 32 +: 32];
    endfunction

    // tree bits are {root, left, right}
    function automatic way_t plru_victim(plru_t t);
        if (!t[2]) return t[0] ? way_t'(2) : way_t'(3);
        return t[1] ? way_t'(0) : way_t'(1);
    endfunction

    function automatic plru_t plru_touch(plru_t t, way_t w);
        plru_t n;
        n    = t;
        n[2] = w[1];
        if (w[1]) n[0] = w[0];
        else n[1] = w[0];
        return n;
    endfunction

    task automatic init_models();
        word_t w;
        for (int i = 0; i < n_lines * 8; i++) begin
            w = (i * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
            mem_lines[i / 8][(i % 8) * 32 +: 32] = w;
            for (int b = 0; b < 4; b++) shadow_bytes[i * 4 + b] = w[b * 8 +: 8];
        end
        for (int s = 0; s < set_count; s++) begin
            sh_tree[s] = '0;
            for (int i = 0; i < way_count; i++) begin
                sh_valid[s][i] = 1'b0;
                sh_dirty[s][i] = 1'b0;
            end
        end
    endtask

    // predict hit or eviction, update the shadow, then run one request
    task automatic do_access(addr_t a, logic wr, byte_mask_t m, word_t d);
        resp_exp_t e;
        mem_op_t op;
        line_t l;
        set_t s;
        tag_t t;
        way_t w;
        logic hit;
        s   = a[8:5];
        t   = a[31:9];
        hit = 1'b0;
        w   = '0;
        for (int i = 0; i < way_count; i++) begin
            if (sh_valid[s][i] && sh_tag[s][i] == t) begin
                hit = 1'b1;
                w   = way_t'(i);
            end
        end
        if (!hit) begin
            w = plru_victim(sh_tree[s]);
            if (sh_valid[s][w] && sh_dirty[s][w]) begin
                op.is_write = 1'b1;
                op.addr     = {sh_tag[s][w], s, 5'b0};
                void'(ref_read_word(op.addr, l));
                op.data = l;
                exp_ops.push_back(op);
            end
            op.is_write = 1'b0;
            op.addr     = {t, s, 5'b0};
            op.data     = '0;
            exp_ops.push_back(op);
            sh_tag[s][w]   = t;
            sh_valid[s][w] = 1'b1;
            sh_dirty[s][w] = 1'b0;
        end
        if (wr) begin
            sh_dirty[s][w] = 1'b1;
            for (int b = 0; b < 4; b++) begin
                if (m[b]) shadow_bytes[{a[11:2], 2'b00} + 12'(b)] = d[b * 8 +: 8];
            end
        end
        sh_tree[s] = plru_touch(sh_tree[s], w);
        e.is_read = !wr;
        e.hit     = hit;
        e.word    = ref_read_word(a, l);
        e.line    = l;
        e.start   = cyc;
        resp_q.push_back(e);
        ufp_addr  = a;
        ufp_rmask = wr ? 4'h0 : m;
        ufp_wmask = wr ? m : 4'h0;
        ufp_wdata = d;
        do @(negedge clk); while (!ufp_resp);
        @(posedge clk);
        #1;
        ufp_rmask = '0;
        ufp_wmask = '0;
    endtask

    // memory model, each level request answered after 1 to 4 cycles
    initial begin
        mem_op_t op;
        int lat;
        dfp_resp  = 1'b0;
        dfp_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst && (dfp_read || dfp_write)) begin
                lat = $urandom_range(1, 4);
                for (int i = 1; i < lat; i++) begin
                    @(posedge clk);
                    #1;
                end
                assert (exp_ops.size() != 0) else begin
                    err_count++;
                    $display("memory access to %h was not expected", dfp_addr);
                end
                if (exp_ops.size() != 0) begin
                    op = exp_ops.pop_front();
                    compare_value("dfp_write", line_t'(dfp_write), line_t'(op.is_write));
                    compare_value("dfp_addr", line_t'(dfp_addr), line_t'(op.addr));
                    if (op.is_write) compare_value("dfp_wdata", dfp_wdata, op.data);
                end
                if (dfp_write) begin
                    mem_lines[dfp_addr[11:5]] = dfp_wdata;
                    wb_count++;
                end else begin
                    dfp_rdata = mem_lines[dfp_addr[11:5]];
                end
                dfp_resp = 1'b1;
                @(posedge clk);
                #1;
                dfp_resp = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && ufp_resp) begin
            assert (resp_q.size() != 0) else begin
                err_count++;
                $display("response arrived with no access outstanding");
            end
            assert (exp_ops.size() == 0) else begin
                err_count++;
                $display("response arrived before %0d memory accesses", exp_ops.size());
            end
            if (resp_q.size() != 0) begin
                exp_resp = resp_q.pop_front();
                if (exp_resp.is_read) begin
                    compare_value("ufp_rdata", line_t'(ufp_rdata), line_t'(exp_resp.word));
                    compare_value("ufp_rline", ufp_rline, exp_resp.line);
                end
                if (exp_resp.hit) begin
                    compare_value("ufp_resp latency", line_t'(cyc - exp_resp.start),
                                  line_t'(3));
                end
            end
        end
    end

    initial begin
        repeat (max_cycles) @(posedge clk);
        $display("timeout after %0d cycles, errors: %0d", max_cycles, err_count);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int wb_before;
        addr_t a;
        rst       = 1'b1;
        ufp_addr  = '0;
        ufp_rmask = '0;
        ufp_wmask = '0;
        ufp_wdata = '0;
        void'($urandom(32'hceba_7ec5));
        init_models();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        // cold read miss, then the same word hits
        do_access(32'h0000_0a2c, 1'b0, 4'hf, '0);
        do_access(32'h0000_0a2c, 1'b0, 4'hf, '0);
        do_access(32'h0000_0a2c, 1'b1, 4'b0101, 32'h1122_3344);
        do_access(32'h0000_0a2c, 1'b0, 4'hf, '0);
        // write miss allocates
        do_access(32'h0000_0c68, 1'b1, 4'b1100, 32'hdead_beef);
        do_access(32'h0000_0c68, 1'b0, 4'hf, '0);
        // five tags in set 7, the dirty first line gets evicted
        do_access(32'h0000_00e4, 1'b1, 4'hf, 32'h0bad_cafe);
        do_access(32'h0000_02e0, 1'b0, 4'hf, '0);
        do_access(32'h0000_04e0, 1'b0, 4'hf, '0);
        do_access(32'h0000_06e0, 1'b0, 4'hf, '0);
        wb_before = wb_count;
        do_access(32'h0000_08e0, 1'b0, 4'hf, '0);
        assert (wb_count == wb_before + 1) else begin
            err_count++;
            $display("dirty victim in set 7 was not written back");
        end
        for (int i = 0; i < n_random; i++) begin
            a = ($urandom_range(0, 5) << 9) | ($urandom_range(0, 3) << 5) |
                ($urandom_range(0, 7) << 2);
            do_access(a, 1'($urandom_range(0, 1)), 4'($urandom_range(1, 15)), $urandom);
        end
        // read every line back through the cache
        for (int i = 0; i < n_lines; i++) begin
            do_access(addr_t'((i << 5) | ((i % 8) << 2)), 1'b0, 4'hf, '0);
        end
        repeat (2) @(posedge clk);
        $display("errors: %0d", err_count);
        if (err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hw/cache_pkg.sv
hw/cache_req_latch.sv
hw/cache_way_store.sv
hw/cache_plru.sv
hw/cache_ctrl.sv
hw/cache_mem_port.sv
hw/cache_top.sv
testbench/tb_cache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= tb_cache
RTL_TOP   ?= cache_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

RTL_SRCS  := $(shell grep '^hw/' $(FILELIST))
ALL_SRCS  := $(shell cat $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

$(SIM_BIN): $(ALL_SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) \
		-o V$(TB_TOP) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qx "Regression passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
